// ==== rtl/pr_cfg_pkg.sv ====
/*
 * build-time constants for the shutdown controller and status counters
 * the drain window is fixed here and cannot be changed from software
 */
package pr_cfg_pkg;

  ////////////////////////////////////////
  // shutdown drain window
  ////////////////////////////////////////

  // drain counter width, must be able to hold PR_DRAIN_CYCLES + 1
  localparam int unsigned DRAIN_CNT_W = 16;

  // cycles the cache gets to retire outstanding work before isolation
  localparam logic [15:0] PR_DRAIN_CYCLES = 16'd2000;

  ////////////////////////////////////////
  // status counters
  ////////////////////////////////////////

  // length of the last shutdown window, wraps only after ~4e9 cycles
  localparam int unsigned PR_CYCLES_W = 32;

  // masked strobe counters saturate at all ones
  localparam int unsigned DROP_CNT_W = 16;

  ////////////////////////////////////////
  // port layout
  ////////////////////////////////////////

  // ports 0 and 1 are read only, port 2 feeds the write buffer
  localparam int unsigned NUM_LSU_PORTS = 3;

  // data_req per port, flush, rtrn_vld, mem_ack
  localparam int unsigned NUM_TO_RP_STROBES = NUM_LSU_PORTS + 3;

  // data_gnt and data_rvalid per port, flush_ack, mem_data_req
  localparam int unsigned NUM_FROM_RP_STROBES = 2 * NUM_LSU_PORTS + 2;

endpackage

// ==== rtl/dcache_bus_pkg.sv ====
/*
 * bundles that cross the partition boundary, all packed so a gate can zero them
 * amo, user bits and way fields are not carried
 */
package dcache_bus_pkg;

  // field widths
  localparam int unsigned INDEX_W = 12;
  localparam int unsigned TAG_W   = 44;
  localparam int unsigned XLEN    = 64;
  localparam int unsigned BE_W    = XLEN / 8;
  localparam int unsigned ID_W    = 4;
  localparam int unsigned RTYPE_W = 3;
  localparam int unsigned PADDR_W = 56;
  localparam int unsigned LINE_W  = 128;
  localparam int unsigned TID_W   = 2;

  ////////////////////////////////////////
  // load/store side
  ////////////////////////////////////////

  // held by the LSU until data_gnt
  typedef struct packed {
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic [XLEN-1:0]    wdata;
    logic [BE_W-1:0]    be;
    logic [1:0]         size;
    logic [ID_W-1:0]    id;
    logic               we;
    logic               data_req;
    logic               kill_req;
    logic               tag_valid;
  } lsu_req_t;

  typedef struct packed {
    logic            data_gnt;
    logic            data_rvalid;
    logic [ID_W-1:0] rid;
    logic [XLEN-1:0] rdata;
  } lsu_rsp_t;

  // flush is held until flush_ack
  typedef struct packed {
    logic enable;
    logic flush;
  } cache_ctrl_t;

  typedef struct packed {
    logic flush_ack;
    logic miss;
    logic wbuffer_empty;
    logic wbuffer_not_ni;
  } cache_stat_t;

  ////////////////////////////////////////
  // memory side
  ////////////////////////////////////////

  // held by the cache until mem_ack
  typedef struct packed {
    logic [RTYPE_W-1:0] rtype;
    logic [2:0]         size;
    logic [PADDR_W-1:0] paddr;
    logic [XLEN-1:0]    data;
    logic               nc;
    logic [TID_W-1:0]   tid;
  } mem_req_t;

  // valid for one cycle with rtrn_vld
  typedef struct packed {
    logic [RTYPE_W-1:0] rtype;
    logic [LINE_W-1:0]  data;
    logic               inv_vld;
    logic               inv_all;
    logic [INDEX_W-1:0] inv_idx;
    logic [TID_W-1:0]   tid;
  } mem_rtrn_t;

  ////////////////////////////////////////
  // boundary bundles
  ////////////////////////////////////////

  typedef struct packed {
    lsu_req_t [pr_cfg_pkg::NUM_LSU_PORTS-1:0] lsu_req;
    cache_ctrl_t                              ctrl;
    mem_rtrn_t                                mem_rtrn;
    logic                                     rtrn_vld;
    logic                                     mem_ack;
  } to_rp_t;

  typedef struct packed {
    lsu_rsp_t [pr_cfg_pkg::NUM_LSU_PORTS-1:0] lsu_rsp;
    cache_stat_t                              stat;
    mem_req_t                                 mem_req;
    logic                                     mem_data_req;
  } from_rp_t;

  typedef struct packed {
    logic [pr_cfg_pkg::DROP_CNT_W-1:0]  drop_to_rp;
    logic [pr_cfg_pkg::DROP_CNT_W-1:0]  drop_from_rp;
    logic [pr_cfg_pkg::PR_CYCLES_W-1:0] pr_cycles;
  } pr_status_t;

endpackage

// ==== rtl/pr_ctrl.sv ====
/*
 * shutdown handshake, the request must stay high for the whole drain window
 * dropping it early aborts the window without an acknowledge
 */
`timescale 1ns/10ps

module pr_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  logic shutdown_req_i,
  input  logic rp_reset_i,
  output logic shutdown_ack_o,
  output logic decouple_o,
  output logic rp_reset_o
);

  typedef enum logic {
    ST_RUN,
    ST_ISOLATED
  } state_e;

  state_e                             state_q;
  state_e                             state_d;
  logic [pr_cfg_pkg::DRAIN_CNT_W-1:0] drain_cnt_q;
  logic [pr_cfg_pkg::DRAIN_CNT_W-1:0] drain_cnt_d;
  logic                               drain_done;

  ////////////////////////////////////////
  // drain window
  ////////////////////////////////////////

  // counter holds the number of edges the request was seen high so far
  assign drain_done = (drain_cnt_q == pr_cfg_pkg::PR_DRAIN_CYCLES);

  always_comb begin
    state_d     = state_q;
    drain_cnt_d = drain_cnt_q;
    unique case (state_q)
      ST_RUN: begin
        if (shutdown_req_i) begin
          drain_cnt_d = drain_cnt_q + 1'b1;
          // window used up, cut the partition off
          if (drain_done) begin
            state_d = ST_ISOLATED;
          end
        end else begin
          // aborted window
          drain_cnt_d = '0;
        end
      end
      ST_ISOLATED: begin
        // stay isolated while software reconfigures
        if (!shutdown_req_i) begin
          state_d     = ST_RUN;
          drain_cnt_d = '0;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_RUN;
      drain_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      drain_cnt_q <= drain_cnt_d;
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // ack and isolation are the same level, software sees ack once gated
  assign decouple_o     = (state_q == ST_ISOLATED);
  assign shutdown_ack_o = (state_q == ST_ISOLATED);

  // partition held in reset with the system or on software request
  assign rp_reset_o = reset_i | rp_reset_i;

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // isolation only ever follows a full window of held request
  a_decouple_after_drain: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(decouple_o) |->
      $past(shutdown_req_i) && ($past(drain_cnt_q) == pr_cfg_pkg::PR_DRAIN_CYCLES)
  );

endmodule

// ==== rtl/pr_gate.sv ====
/*
 * zero-latency isolation gate, payload reads as all zero while decoupled
 * drop count saturates at all ones and clears only on reset
 */
`timescale 1ns/10ps

module pr_gate #(
  parameter type         payload_t  = logic [31:0],
  parameter int unsigned NumStrobes = 1
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              decouple_i,
  input  payload_t                          data_i,
  input  logic [NumStrobes-1:0]             strobe_i,
  output payload_t                          data_o,
  output logic [pr_cfg_pkg::DROP_CNT_W-1:0] drop_cnt_o
);

  logic [pr_cfg_pkg::DROP_CNT_W-1:0] drop_cnt_q;
  logic                              drop_hit;
  logic                              drop_sat;

  ////////////////////////////////////////
  // isolation
  ////////////////////////////////////////

  // strobes included, so nothing on the far side sees a request or a grant
  assign data_o = decouple_i ? payload_t'('0) : data_i;

  ////////////////////////////////////////
  // masked strobe counter
  ////////////////////////////////////////

  // one count per cycle, however many strobes are up
  assign drop_hit = decouple_i & (|strobe_i);
  assign drop_sat = &drop_cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      drop_cnt_q <= '0;
    end else if (drop_hit && !drop_sat) begin
      drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  assign drop_cnt_o = drop_cnt_q;

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // nothing may leak across the boundary while the partition is cut off
  a_isolated_zero: assert property (
    @(posedge clk_i) disable iff (reset_i)
    decouple_i |-> (data_o == payload_t'('0))
  );

endmodule

// ==== rtl/pr_stats.sv ====
/*
 * length of the last shutdown window in cycles, aborted windows included
 * value updates one edge after the request drops
 */
`timescale 1ns/10ps

module pr_stats (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               shutdown_req_i,
  output logic [pr_cfg_pkg::PR_CYCLES_W-1:0] pr_cycles_o
);

  logic [pr_cfg_pkg::PR_CYCLES_W-1:0] run_cnt_q;
  logic [pr_cfg_pkg::PR_CYCLES_W-1:0] hold_q;
  logic                               req_q;
  logic                               req_fall;

  // first edge with the request low after at least one high edge
  assign req_fall = req_q & ~shutdown_req_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q     <= 1'b0;
      run_cnt_q <= '0;
      hold_q    <= '0;
    end else begin
      req_q <= shutdown_req_i;
      if (shutdown_req_i) begin
        run_cnt_q <= run_cnt_q + 1'b1;
      end else begin
        run_cnt_q <= '0;
      end
      // keep the finished window until the next one ends
      if (req_fall) begin
        hold_q <= run_cnt_q;
      end
    end
  end

  assign pr_cycles_o = hold_q;

endmodule

// ==== rtl/dcache_pr_shell.sv ====
/*
 * boundary shell around a data cache in a reconfigurable partition
 * isolation is entered only through the shutdown handshake, no separate pin
 */
`timescale 1ns/10ps

module dcache_pr_shell (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      rp_reset_i,
  input  logic                      shutdown_req_i,
  output logic                      shutdown_ack_o,
  output logic                      rp_reset_o,
  // static side toward the partition
  input  dcache_bus_pkg::to_rp_t    s_to_rp_i,
  output dcache_bus_pkg::to_rp_t    rp_to_rp_o,
  // partition toward the static side
  input  dcache_bus_pkg::from_rp_t  rp_from_rp_i,
  output dcache_bus_pkg::from_rp_t  s_from_rp_o,
  // software status
  output dcache_bus_pkg::pr_status_t pr_status_o
);

  localparam int unsigned NPorts = pr_cfg_pkg::NUM_LSU_PORTS;

  logic                                       decouple;
  logic [pr_cfg_pkg::NUM_TO_RP_STROBES-1:0]   to_rp_strb;
  logic [pr_cfg_pkg::NUM_FROM_RP_STROBES-1:0] from_rp_strb;
  logic [pr_cfg_pkg::DROP_CNT_W-1:0]          drop_to_rp;
  logic [pr_cfg_pkg::DROP_CNT_W-1:0]          drop_from_rp;
  logic [pr_cfg_pkg::PR_CYCLES_W-1:0]         pr_cycles;

  ////////////////////////////////////////
  // shutdown handshake
  ////////////////////////////////////////

  pr_ctrl u_pr_ctrl (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .shutdown_req_i ( shutdown_req_i ),
    .rp_reset_i     ( rp_reset_i     ),
    .shutdown_ack_o ( shutdown_ack_o ),
    .decouple_o     ( decouple       ),
    .rp_reset_o     ( rp_reset_o     )
  );

  ////////////////////////////////////////
  // strobe extraction
  ////////////////////////////////////////

  // per port strobes in the low bits, shared ones on top
  for (genvar p = 0; p < NPorts; p++) begin : g_port_strb
    assign to_rp_strb[p]          = s_to_rp_i.lsu_req[p].data_req;
    assign from_rp_strb[p]        = rp_from_rp_i.lsu_rsp[p].data_gnt;
    assign from_rp_strb[NPorts+p] = rp_from_rp_i.lsu_rsp[p].data_rvalid;
  end

  assign to_rp_strb[NPorts]   = s_to_rp_i.ctrl.flush;
  assign to_rp_strb[NPorts+1] = s_to_rp_i.rtrn_vld;
  assign to_rp_strb[NPorts+2] = s_to_rp_i.mem_ack;

  assign from_rp_strb[2*NPorts]   = rp_from_rp_i.stat.flush_ack;
  assign from_rp_strb[2*NPorts+1] = rp_from_rp_i.mem_data_req;

  ////////////////////////////////////////
  // isolation gates
  ////////////////////////////////////////

  pr_gate #(
    .payload_t  ( dcache_bus_pkg::to_rp_t       ),
    .NumStrobes ( pr_cfg_pkg::NUM_TO_RP_STROBES )
  ) u_gate_to_rp (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .decouple_i ( decouple   ),
    .data_i     ( s_to_rp_i  ),
    .strobe_i   ( to_rp_strb ),
    .data_o     ( rp_to_rp_o ),
    .drop_cnt_o ( drop_to_rp )
  );

  // a decoupled partition reads as no grant, no ack, no return
  pr_gate #(
    .payload_t  ( dcache_bus_pkg::from_rp_t       ),
    .NumStrobes ( pr_cfg_pkg::NUM_FROM_RP_STROBES )
  ) u_gate_from_rp (
    .clk_i      ( clk_i        ),
    .reset_i    ( reset_i      ),
    .decouple_i ( decouple     ),
    .data_i     ( rp_from_rp_i ),
    .strobe_i   ( from_rp_strb ),
    .data_o     ( s_from_rp_o  ),
    .drop_cnt_o ( drop_from_rp )
  );

  ////////////////////////////////////////
  // window statistics
  ////////////////////////////////////////

  pr_stats u_pr_stats (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .shutdown_req_i ( shutdown_req_i ),
    .pr_cycles_o    ( pr_cycles      )
  );

  assign pr_status_o = '{
    drop_to_rp:   drop_to_rp,
    drop_from_rp: drop_from_rp,
    pr_cycles:    pr_cycles
  };

endmodule

// ==== dv/tb_dcache_pr_shell.sv ====
/*
 * testbench for the partition shell, checked by assertions against a small reference model
 * drain length comes from pr_cfg_pkg, the run is bounded by a cycle limit
 */
`timescale 1ns/10ps

module tb_dcache_pr_shell;

  localparam int unsigned TO_W       = $bits(dcache_bus_pkg::to_rp_t);
  localparam int unsigned FROM_W     = $bits(dcache_bus_pkg::from_rp_t);
  localparam int unsigned NPORTS     = pr_cfg_pkg::NUM_LSU_PORTS;
  localparam int unsigned DRAIN      = int'(pr_cfg_pkg::PR_DRAIN_CYCLES);
  // four windows of at most ~2100 cycles plus traffic, with margin
  localparam int unsigned MAX_CYCLES = 12000;

  logic                       clk_i;
  logic                       reset_i;
  logic                       rp_reset_i;
  logic                       shutdown_req_i;
  logic                       shutdown_ack_o;
  logic                       rp_reset_o;
  dcache_bus_pkg::to_rp_t     s_to_rp_i;
  dcache_bus_pkg::to_rp_t     rp_to_rp_o;
  dcache_bus_pkg::from_rp_t   rp_from_rp_i;
  dcache_bus_pkg::from_rp_t   s_from_rp_o;
  dcache_bus_pkg::pr_status_t pr_status_o;

  logic [31:0]                       lfsr_q;
  int unsigned                       cycle_cnt = 0;
  int unsigned                       hi_edges = 0;
  logic                              exp_iso;
  logic [pr_cfg_pkg::DROP_CNT_W-1:0] exp_drop_to;
  logic [pr_cfg_pkg::DROP_CNT_W-1:0] exp_drop_from;
  int unsigned                       ack_errs = 0;
  int unsigned                       gate_errs = 0;
  int unsigned                       count_errs = 0;
  int unsigned                       reset_errs = 0;

  dcache_pr_shell u_dcache_pr_shell (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .rp_reset_i     ( rp_reset_i     ),
    .shutdown_req_i ( shutdown_req_i ),
    .shutdown_ack_o ( shutdown_ack_o ),
    .rp_reset_o     ( rp_reset_o     ),
    .s_to_rp_i      ( s_to_rp_i      ),
    .rp_to_rp_o     ( rp_to_rp_o     ),
    .rp_from_rp_i   ( rp_from_rp_i   ),
    .s_from_rp_o    ( s_from_rp_o    ),
    .pr_status_o    ( pr_status_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int unsigned n, output logic [1023:0] v);
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // strobes as listed for each direction of the boundary
  function automatic logic any_to_strobe(input dcache_bus_pkg::to_rp_t b);
    logic        hit;
    int unsigned p;
    hit = b.ctrl.flush | b.rtrn_vld | b.mem_ack;
    for (p = 0; p < NPORTS; p++) begin
      hit = hit | b.lsu_req[p].data_req;
    end
    return hit;
  endfunction

  function automatic logic any_from_strobe(input dcache_bus_pkg::from_rp_t b);
    logic        hit;
    int unsigned p;
    hit = b.stat.flush_ack | b.mem_data_req;
    for (p = 0; p < NPORTS; p++) begin
      hit = hit | b.lsu_rsp[p].data_gnt | b.lsu_rsp[p].data_rvalid;
    end
    return hit;
  endfunction

  // isolated once the request has been seen high for drain + 1 edges in a row
  assign exp_iso = (hi_edges > DRAIN);

  always @(posedge clk_i) begin
    if (reset_i) begin
      hi_edges      <= 0;
      exp_drop_to   <= '0;
      exp_drop_from <= '0;
    end else begin
      hi_edges <= shutdown_req_i ? hi_edges + 1 : 0;
      if (exp_iso && any_to_strobe(s_to_rp_i) && exp_drop_to != '1) begin
        exp_drop_to <= exp_drop_to + 1'b1;
      end
      if (exp_iso && any_from_strobe(rp_from_rp_i) && exp_drop_from != '1) begin
        exp_drop_from <= exp_drop_from + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    shutdown_ack_o == exp_iso)
  else begin
    ack_errs++;
    $display("mismatch at %0t: shutdown_ack_o is %0b, expected %0b",
             $time, $sampled(shutdown_ack_o), $sampled(exp_iso));
  end

  a_transparent: assert property (@(posedge clk_i) disable iff (reset_i)
    !exp_iso |-> (rp_to_rp_o == s_to_rp_i) && (s_from_rp_o == rp_from_rp_i))
  else begin
    gate_errs++;
    $display("mismatch at %0t: gated bundle differs from its input", $time);
  end

  a_isolated: assert property (@(posedge clk_i) disable iff (reset_i)
    exp_iso |-> (rp_to_rp_o == '0) && (s_from_rp_o == '0))
  else begin
    gate_errs++;
    $display("mismatch at %0t: bundle not zero while isolated", $time);
  end

  a_drop_counts: assert property (@(posedge clk_i) disable iff (reset_i)
    (pr_status_o.drop_to_rp == exp_drop_to) && (pr_status_o.drop_from_rp == exp_drop_from))
  else begin
    count_errs++;
    $display("mismatch at %0t: drop counts %0d/%0d, expected %0d/%0d", $time,
             $sampled(pr_status_o.drop_to_rp), $sampled(pr_status_o.drop_from_rp),
             $sampled(exp_drop_to), $sampled(exp_drop_from));
  end

  a_rp_reset: assert property (@(posedge clk_i) rp_reset_o == (reset_i | rp_reset_i))
  else begin
    reset_errs++;
    $display("mismatch at %0t: rp_reset_o is %0b", $time, $sampled(rp_reset_o));
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic clear_strobes();
    int unsigned p;
    for (p = 0; p < NPORTS; p++) begin
      s_to_rp_i.lsu_req[p].data_req       = 1'b0;
      rp_from_rp_i.lsu_rsp[p].data_gnt    = 1'b0;
      rp_from_rp_i.lsu_rsp[p].data_rvalid = 1'b0;
    end
    s_to_rp_i.ctrl.flush            = 1'b0;
    s_to_rp_i.rtrn_vld              = 1'b0;
    s_to_rp_i.mem_ack               = 1'b0;
    rp_from_rp_i.stat.flush_ack     = 1'b0;
    rp_from_rp_i.mem_data_req       = 1'b0;
  endtask

  task automatic randomize_inputs();
    logic [1023:0] v;
    logic [2:0]    ctl;
    take_bits(TO_W, v);
    s_to_rp_i = dcache_bus_pkg::to_rp_t'(v[TO_W-1:0]);
    take_bits(FROM_W, v);
    rp_from_rp_i = dcache_bus_pkg::from_rp_t'(v[FROM_W-1:0]);
    take_bits(3, v);
    ctl = v[2:0];
    // partition reset now and then
    rp_reset_i = &ctl;
    // some idle cycles so the drop counters also see strobe-free input
    if (ctl == 3'b000) begin
      clear_strobes();
    end
  endtask

  task automatic run_traffic(input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      shutdown_req_i = 1'b0;
      randomize_inputs();
    end
  endtask

  // holds the request for n edges with traffic, then drops it
  task automatic run_window(input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      shutdown_req_i = 1'b1;
      randomize_inputs();
    end
    @(negedge clk_i);
    shutdown_req_i = 1'b0;
    randomize_inputs();
    @(negedge clk_i);
    a_window: assert (pr_status_o.pr_cycles == n)
    else begin
      count_errs++;
      $display("mismatch at %0t: pr_cycles is %0d, expected %0d",
               $time, pr_status_o.pr_cycles, n);
    end
    randomize_inputs();
  endtask

  initial begin : main_seq
    int unsigned total;
    lfsr_q         = 32'hecb4_88b5;
    reset_i        = 1'b1;
    rp_reset_i     = 1'b0;
    shutdown_req_i = 1'b0;
    s_to_rp_i      = '0;
    rp_from_rp_i   = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    run_traffic(200);
    // aborted window
    run_window(300);
    run_traffic(50);
    // full window with isolated traffic
    run_window(DRAIN + 1 + 60);
    run_traffic(50);
    // one edge short of the acknowledge
    run_window(DRAIN);
    run_traffic(20);
    // acknowledge for a single cycle
    run_window(DRAIN + 1);
    run_traffic(50);

    repeat (2) @(negedge clk_i);
    total = ack_errs + gate_errs + count_errs + reset_errs;
    $display("errors: ack %0d, gate %0d, count %0d, reset %0d",
             ack_errs, gate_errs, count_errs, reset_errs);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
rtl/pr_cfg_pkg.sv
rtl/dcache_bus_pkg.sv
rtl/pr_ctrl.sv
rtl/pr_gate.sv
rtl/pr_stats.sv
rtl/dcache_pr_shell.sv
dv/tb_dcache_pr_shell.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      := tb_dcache_pr_shell
FILELIST := verilog.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Simulation completed successfully
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
